/* filelist.f */
+incdir+verilog
verilog/game_pkg.sv
verilog/max7219_pkg.sv
verilog/game_if.sv
verilog/button_debounce.sv
verilog/step_timer.sv
verilog/game_fsm.sv
verilog/playfield.sv
verilog/max7219_driver.sv
verilog/road_game_top.sv
test/tb_road_game.sv

/* run_sim.sh */
#!/bin/sh
# Builds the road game testbench with Verilator and runs it.
# The run fails when the log holds the fail message or the build breaks.

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_road_game -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vtb_road_game > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "ERRORS FOUND" sim.log &&
{ echo "Simulation failed, see sim.log"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

/* test/tb_road_game.sv */
// Road game testbench
// Decodes the MAX7219 serial stream into frames and checks them against
// a model of the screens, scrolling road and player lane
`timescale 1ns/100ps
`default_nettype none
`include "game_params.svh"

module tb_road_game;
	import game_pkg::*;
	import max7219_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int VALID_HOLD  = `DEBOUNCE_LEN + 6;
	localparam int SHORT_HOLD  = `DEBOUNCE_LEN - 4;
	localparam int TOTAL_STEPS = `LEVEL_COUNT * `PROGRESS_PER_LEVEL;
	// Splash, end, restart and button time on top of the play time
	localparam int WATCHDOG_MARGIN = 70000;

	localparam max_reg_e   INIT_ADDR [4] = '{DECODE_MODE, SCAN_LIMIT, INTENSITY, SHUTDOWN};
	localparam logic [7:0] INIT_DATA [4] = '{8'h00, 8'h07, 8'(`MAX_INTENSITY), 8'h01};

	logic clock_50;
	logic rst;
	logic start_n;
	logic left_n;
	logic right_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	int          error_count;
	int          word_count;
	int          frame_count;
	logic [15:0] shift_in;
	frame_t      rx_frame;
	time         ncs_high_at;

	// Model state
	screen_e   exp_screen;
	int        screen_pend;
	frame_t    exp_road;
	row_t      exp_player;
	row_t      prev_player;
	int        player_pend;
	progress_t exp_progress;
	level_t    exp_level;
	int        steps_seen;

	road_game_top dut_i (
		.clock_50    (clock_50),
		.rst         (rst),
		.start_n     (start_n),
		.left_n      (left_n),
		.right_n     (right_n),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	initial clock_50 = 1'b0;
	always #(CLK_PERIOD / 2) clock_50 = ~clock_50;

	function automatic void log_error(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		error_count++;
	endfunction

	function automatic row_t rotate_left(input row_t value, input int amount);
		row_t r;
		r = value;
		repeat (amount) r = {r[6:0], r[7]};
		return r;
	endfunction

	// Rows 0..6 are road only and row 7 carries the car too
	function automatic logic road_matches(input frame_t f, input frame_t road);
		logic ok;
		ok = (f[0:6] == road[0:6]);
		ok = ok && ((f[7] == (road[7] | exp_player)) ||
			(player_pend > 0 && f[7] == (road[7] | prev_player)));
		return ok;
	endfunction

	// --------------------
	// Serial protocol checks
	assert property (@(posedge clock_50) disable iff (rst) max7219_ncs |-> !max7219_clk)
		else log_error("serial clock high while chip select inactive");

	assert property (@(posedge clock_50) disable iff (rst)
		(max7219_din != $past(max7219_din)) |-> !max7219_clk)
		else log_error("din changed while serial clock high");

	// --------------------
	// Play frame against current or next road state
	task automatic check_play_frame(input frame_t f);
		frame_t next_road;
		int     i;
		next_road[0] = rotate_left(OBSTACLE_TABLE[exp_progress], int'(exp_level));
		for (i = 1; i < 8; i++)
			next_road[i] = exp_road[i - 1];
		if (f == END_IMAGE) begin
			// Last step enters END before its own road is shown
			assert (steps_seen == TOTAL_STEPS - 1)
			else log_error($sformatf("end screen after %0d road steps", steps_seen));
			exp_screen = SCREEN_END;
		end else if (screen_pend > 0 && f == SPLASH_IMAGE) begin
			// Frame from before the start press
		end else if (!road_matches(f, exp_road)) begin
			assert (road_matches(f, next_road))
			else log_error($sformatf("road frame %h is not the next step", f));
			exp_road = next_road;
			steps_seen++;
			if (exp_progress == progress_t'(`PROGRESS_PER_LEVEL - 1)) begin
				exp_progress = '0;
				exp_level    = exp_level + 1'b1;
			end else begin
				exp_progress = exp_progress + 1'b1;
			end
		end
	endtask

	task automatic check_frame(input frame_t f);
		frame_count++;
		case (exp_screen)
			SCREEN_SPLASH: begin
				assert (f == SPLASH_IMAGE || (screen_pend > 0 && f == END_IMAGE))
				else log_error($sformatf("frame %h is not the splash image", f));
			end
			SCREEN_END: begin
				assert (f == END_IMAGE)
				else log_error($sformatf("frame %h is not the end image", f));
			end
			default: check_play_frame(f);
		endcase
		if (screen_pend > 0)
			screen_pend--;
		if (player_pend > 0)
			player_pend--;
	endtask

	// Init words first and DIGIT0..DIGIT7 in a loop after them
	task automatic handle_word(input logic [7:0] addr, input logic [7:0] data);
		int row;
		if (word_count < 4) begin
			assert (addr == INIT_ADDR[word_count] && data == INIT_DATA[word_count])
			else log_error($sformatf("init word %0d is %h%h", word_count, addr, data));
		end else begin
			row = (word_count - 4) % 8;
			assert (addr == 8'(DIGIT0) + 8'(row))
			else log_error($sformatf("digit word address %h, row %0d expected", addr, row));
			rx_frame[row] = data;
			if (row == 7)
				check_frame(rx_frame);
		end
		word_count++;
	endtask

	// --------------------
	// Serial decoder
	always @(posedge max7219_clk) begin
		shift_in <= {shift_in[14:0], max7219_din};
	end

	always @(posedge max7219_ncs) begin
		ncs_high_at = $time;
		if (!rst)
			handle_word(shift_in[15:8], shift_in[7:0]);
	end

	always @(negedge max7219_ncs) begin
		if (word_count > 0)
			assert ($time - ncs_high_at >= `SCLK_HALF * CLK_PERIOD)
			else log_error("chip select gap between words too short");
	end

	// --------------------
	// Stimulus helpers
	task automatic set_button(input int which, input logic level);
		case (which)
			0:       start_n = level;
			1:       left_n  = level;
			default: right_n = level;
		endcase
	endtask

	task automatic press(input int which, input int cycles);
		@(posedge clock_50);
		#DRIVE_DELAY;
		set_button(which, 1'b0);
		repeat (cycles) @(posedge clock_50);
		#DRIVE_DELAY;
		set_button(which, 1'b1);
	endtask

	task automatic wait_frames(input int count);
		int target;
		target = frame_count + count;
		wait (frame_count >= target);
	endtask

	// One lane move that saturates at the matrix edges
	task automatic move_player(input logic go_left);
		press(go_left ? 1 : 2, VALID_HOLD);
		prev_player = exp_player;
		if (go_left) begin
			if (!exp_player[7])
				exp_player = exp_player << 1;
		end else if (!exp_player[0]) begin
			exp_player = exp_player >> 1;
		end
		// One frame may still hold the old snapshot
		player_pend = 1;
		wait_frames(2);
	endtask

	// --------------------
	initial begin : stimulus
		int   n;
		logic go_left;
		error_count  = 0;
		word_count   = 0;
		frame_count  = 0;
		ncs_high_at  = 0;
		exp_screen   = SCREEN_SPLASH;
		screen_pend  = 0;
		exp_road     = '0;
		exp_player   = PLAYER_START;
		prev_player  = PLAYER_START;
		player_pend  = 0;
		exp_progress = '0;
		exp_level    = '0;
		steps_seen   = 0;
		start_n      = 1'b1;
		left_n       = 1'b1;
		right_n      = 1'b1;
		rst          = 1'b1;
		void'($urandom(32'h525975ee));
		repeat (2) @(posedge clock_50);
		#DRIVE_DELAY;
		rst = 1'b0;
		assert (max7219_ncs === 1'b1 && max7219_clk === 1'b0)
		else log_error("serial outputs not idle after reset");

		// Splash survives a short start press
		wait_frames(2);
		press(0, SHORT_HOLD);
		wait_frames(3);

		// Valid start gives a fresh road and car
		press(0, VALID_HOLD);
		exp_screen  = SCREEN_PLAY;
		screen_pend = 1;
		wait_frames(2);

		// Both edges first and random lanes after them
		repeat (4) move_player(1'b1);
		repeat (8) move_player(1'b0);
		for (n = 0; n < 12; n++) begin
			go_left = 1'($urandom() % 2);
			move_player(go_left);
		end

		// Game end and return to splash
		wait (exp_screen == SCREEN_END);
		wait_frames(2);
		press(0, VALID_HOLD);
		exp_screen  = SCREEN_SPLASH;
		screen_pend = 1;
		wait_frames(3);

		$display("Run complete: %0d errors, %0d frames decoded", error_count, frame_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Play time of all levels plus margin
	initial begin : watchdog
		int limit;
		int lvl;
		limit = WATCHDOG_MARGIN;
		for (lvl = 0; lvl < `LEVEL_COUNT; lvl++)
			limit += (`STEP_BASE_CYCLES >> lvl) * `PROGRESS_PER_LEVEL;
		repeat (limit) @(posedge clock_50);
		$display("Timeout: the game did not finish within %0d clock cycles", limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/button_debounce.sv */
// Button debouncer
// Filters one active-low push button and pulses press once per press
`timescale 1ns/100ps
`default_nettype none
`include "game_params.svh"

module button_debounce (
	input  logic clock_50,
	input  logic rst,
	input  logic button_n,
	output logic press
);
	localparam int CNT_W = $clog2(`DEBOUNCE_LEN);

	// Two-flop synchronizer, idle high
	logic [1:0]       sync;
	// Accepted level, high means released
	logic             accepted;
	// Cycles the input has disagreed with accepted
	logic [CNT_W-1:0] count;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			sync     <= 2'b11;
			accepted <= 1'b1;
			count    <= '0;
			press    <= 1'b0;
		end else begin
			sync  <= {sync[0], button_n};
			press <= 1'b0;
			if (sync[1] == accepted) begin
				// Bounce back, start over
				count <= '0;
			end else if (count == CNT_W'(`DEBOUNCE_LEN - 1)) begin
				count    <= '0;
				accepted <= sync[1];
				// Strobe on the press edge only
				press    <= !sync[1];
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/game_fsm.sv */
// Screen state machine
// Splash, play and end screens with level and progress counters
`timescale 1ns/100ps
`default_nettype none
`include "game_params.svh"

module game_fsm (
	input  logic clock_50,
	input  logic rst,
	input  logic start_press,
	game_if.ctrl gif
);
	import game_pkg::*;

	localparam progress_t LAST_PROGRESS = progress_t'(`PROGRESS_PER_LEVEL - 1);
	localparam level_t    LAST_LEVEL    = level_t'(`LEVEL_COUNT - 1);

	always_ff @(posedge clock_50) begin
		if (rst) begin
			gif.screen   <= SCREEN_SPLASH;
			gif.start    <= 1'b0;
			gif.level    <= '0;
			gif.progress <= '0;
		end else begin
			gif.start <= 1'b0;
			case (gif.screen)
				SCREEN_SPLASH: begin
					if (start_press) begin
						// New game from the first row of level 0
						gif.screen   <= SCREEN_PLAY;
						gif.start    <= 1'b1;
						gif.level    <= '0;
						gif.progress <= '0;
					end
				end
				SCREEN_PLAY: begin
					if (gif.step) begin
						if (gif.progress == LAST_PROGRESS) begin
							gif.progress <= '0;
							// Last step of last level ends the game
							if (gif.level == LAST_LEVEL)
								gif.screen <= SCREEN_END;
							else
								gif.level <= gif.level + 1'b1;
						end else begin
							gif.progress <= gif.progress + 1'b1;
						end
					end
				end
				SCREEN_END: begin
					// Back to splash, counters cleared on next start
					if (start_press)
						gif.screen <= SCREEN_SPLASH;
				end
				default: begin
					gif.screen <= SCREEN_SPLASH;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/game_if.sv */
// Game control bundle
// Screen, start pulse, step pulse, level and progress shared in the core
`timescale 1ns/100ps
`default_nettype none

interface game_if;
	import game_pkg::*;

	screen_e   screen;
	// One-cycle pulse on entering play
	logic      start;
	// One-cycle pacing pulse
	logic      step;
	level_t    level;
	progress_t progress;

	modport ctrl (output screen, output start, output level, output progress, input step);
	modport timer (input screen, input level, output step);
	modport field (input screen, input start, input step, input level, input progress);

endinterface

`default_nettype wire

/* verilog/game_params.svh */
// Road game tuning constants
// Debounce, pacing, level layout and MAX7219 serial settings
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// Stable cycles before a button level is accepted
`define DEBOUNCE_LEN 16

// Step period at level 0, halved on every level
`define STEP_BASE_CYCLES 8192
`define LEVEL_COUNT 4
`define PROGRESS_PER_LEVEL 8

// System cycles per serial clock half period
`define SCLK_HALF 2

// MAX7219 intensity register value
`define MAX_INTENSITY 10

`endif

/* verilog/game_pkg.sv */
// Road game types and constants
// Screen enum, matrix row and frame types, fixed images and obstacle table
`default_nettype none

package game_pkg;

	// One matrix row, bit 7 is the leftmost LED
	typedef logic [7:0] row_t;

	// Index 0 is digit 1, the top row
	typedef row_t [0:7] frame_t;

	typedef logic [1:0] level_t;
	typedef logic [2:0] progress_t;

	// Screen FSM states
	typedef enum logic [1:0] {
		SCREEN_SPLASH = 2'd0,
		SCREEN_PLAY   = 2'd1,
		SCREEN_END    = 2'd2
	} screen_e;

	// --------------------
	// Fixed images, top row first
	localparam frame_t SPLASH_IMAGE = {
		8'b00010000, 8'b00000000, 8'b00010000, 8'b00111000,
		8'b01111100, 8'b01111100, 8'b00111000, 8'b00010000
	};

	// Letter E
	localparam frame_t END_IMAGE = {
		8'b00000000, 8'b01111100, 8'b01000000, 8'b01111100,
		8'b01000000, 8'b01111100, 8'b00000000, 8'b00000000
	};

	// --------------------
	// Obstacle rows by progress, rotated left by level
	localparam row_t [0:7] OBSTACLE_TABLE = {
		8'b00011000, 8'b00000000, 8'b11000000, 8'b00000000,
		8'b00000011, 8'b00000000, 8'b00100100, 8'b00000000
	};

	// Car starts in lane 5
	localparam row_t PLAYER_START = 8'b00100000;

endpackage

`default_nettype wire

/* verilog/max7219_driver.sv */
// MAX7219 serial driver
// Sends the init words once, then refreshes all eight digit rows forever
// Each refresh pass works on a frame snapshot taken at its start
`timescale 1ns/100ps
`default_nettype none
`include "game_params.svh"

module max7219_driver (
	input  logic             clock_50,
	input  logic             rst,
	input  game_pkg::frame_t frame,
	output logic             max7219_din,
	output logic             max7219_ncs,
	output logic             max7219_clk
);
	import game_pkg::*;
	import max7219_pkg::*;

	localparam int DIV_W = $clog2(`SCLK_HALF + 1);
	// Words 0..3 are init, 4..11 are digit rows
	localparam logic [3:0] FIRST_DIGIT = 4'd4;
	localparam logic [3:0] LAST_WORD   = 4'd11;

	drv_state_e       state;
	logic [3:0]       word_idx;
	logic [3:0]       bit_cnt;
	logic [DIV_W-1:0] div;
	// Bits still to send, MSB next
	logic [15:0]      shreg;
	frame_t           snapshot;
	max_reg_e         word_addr;
	row_t             word_data;
	logic [2:0]       row_sel;
	logic             half_done;

	assign half_done = (div == DIV_W'(`SCLK_HALF - 1));

	// --------------------
	// Word contents by index
	always_comb begin
		row_sel = 3'(word_idx - FIRST_DIGIT);
		case (word_idx)
			4'd0: begin
				word_addr = DECODE_MODE;
				word_data = 8'h00;
			end
			4'd1: begin
				word_addr = SCAN_LIMIT;
				word_data = 8'h07;
			end
			4'd2: begin
				word_addr = INTENSITY;
				word_data = 8'(`MAX_INTENSITY);
			end
			4'd3: begin
				word_addr = SHUTDOWN;
				word_data = 8'h01;
			end
			default: begin
				word_addr = max_reg_e'(DIGIT0 + row_sel);
				word_data = snapshot[row_sel];
			end
		endcase
	end

	// --------------------
	// Word sequencer and bit shifter
	always_ff @(posedge clock_50) begin
		if (rst) begin
			state       <= IDLE;
			word_idx    <= '0;
			bit_cnt     <= '0;
			div         <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else begin
			case (state)
				IDLE: state <= LOAD;
				LOAD: begin
					// Select chip, first bit out with clk low
					shreg       <= {word_addr[6:0], word_data, 1'b0};
					max7219_din <= word_addr[7];
					max7219_ncs <= 1'b0;
					bit_cnt     <= '0;
					div         <= '0;
					state       <= SHIFT;
				end
				SHIFT: begin
					div <= div + 1'b1;
					if (half_done) begin
						div <= '0;
						if (!max7219_clk) begin
							max7219_clk <= 1'b1;
						end else begin
							// Falling edge, next bit or end of word
							max7219_clk <= 1'b0;
							if (bit_cnt == 4'd15) begin
								max7219_ncs <= 1'b1;
								max7219_din <= 1'b0;
								state       <= GAP;
							end else begin
								bit_cnt     <= bit_cnt + 1'b1;
								max7219_din <= shreg[15];
								shreg       <= {shreg[14:0], 1'b0};
							end
						end
					end
				end
				GAP: begin
					div <= div + 1'b1;
					if (half_done) begin
						div   <= '0;
						state <= LOAD;
						// After init or a full pass start a new refresh
						if (word_idx == FIRST_DIGIT - 1'b1 || word_idx == LAST_WORD) begin
							word_idx <= FIRST_DIGIT;
							snapshot <= frame;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/max7219_pkg.sv */
// MAX7219 controller definitions
// Register address map and serial driver states
`default_nettype none

package max7219_pkg;

	// Register addresses, upper byte of each serial word
	typedef enum logic [7:0] {
		NOOP         = 8'h00,
		DIGIT0       = 8'h01,
		DIGIT1       = 8'h02,
		DIGIT2       = 8'h03,
		DIGIT3       = 8'h04,
		DIGIT4       = 8'h05,
		DIGIT5       = 8'h06,
		DIGIT6       = 8'h07,
		DIGIT7       = 8'h08,
		DECODE_MODE  = 8'h09,
		INTENSITY    = 8'h0A,
		SCAN_LIMIT   = 8'h0B,
		SHUTDOWN     = 8'h0C,
		DISPLAY_TEST = 8'h0F
	} max_reg_e;

	// Driver FSM
	typedef enum logic [1:0] {IDLE, LOAD, SHIFT, GAP} drv_state_e;

endpackage

`default_nettype wire

/* verilog/playfield.sv */
// Playfield
// Scrolling obstacle rows, player lane and screen content selection
`timescale 1ns/100ps
`default_nettype none

module playfield (
	input  logic             clock_50,
	input  logic             rst,
	input  logic             left_press,
	input  logic             right_press,
	game_if.field            gif,
	output game_pkg::frame_t frame
);
	import game_pkg::*;

	// Road rows, index 0 at the top
	frame_t road;
	// One-hot car position on the bottom row
	row_t   player;
	row_t   table_row;
	row_t   new_row;
	frame_t play_frame;

	// --------------------
	// New top row, table entry rotated left by level
	always_comb begin
		table_row = OBSTACLE_TABLE[gif.progress];
		new_row   = row_t'({table_row, table_row} >> (4'd8 - 4'(gif.level)));
	end

	// Car merged onto the bottom road row
	always_comb begin
		play_frame    = road;
		play_frame[7] = road[7] | player;
	end

	// --------------------
	always_ff @(posedge clock_50) begin
		if (rst || gif.start || gif.screen != SCREEN_PLAY) begin
			// Empty road and car at start outside play
			road   <= '0;
			player <= PLAYER_START;
		end else begin
			// Scroll down, bottom row drops off
			if (gif.step)
				road <= {new_row, road[0:6]};
			// Lane moves saturate at the edges
			if (left_press) begin
				if (!player[7])
					player <= {player[6:0], 1'b0};
			end else if (right_press) begin
				if (!player[0])
					player <= {1'b0, player[7:1]};
			end
		end
	end

	// Registered screen select
	always_ff @(posedge clock_50) begin
		if (rst) begin
			frame <= SPLASH_IMAGE;
		end else begin
			case (gif.screen)
				SCREEN_PLAY: frame <= play_frame;
				SCREEN_END:  frame <= END_IMAGE;
				default:     frame <= SPLASH_IMAGE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/road_game_top.sv */
// Road game top level
// Three debounced buttons, game core and MAX7219 matrix driver
`timescale 1ns/100ps
`default_nettype none

module road_game_top (
	input  logic clock_50,
	input  logic rst,
	input  logic start_n,
	input  logic left_n,
	input  logic right_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);
	import game_pkg::*;

	// Press strobes
	logic   start_press;
	logic   left_press;
	logic   right_press;
	// Composed matrix image
	frame_t frame;

	game_if gif ();

	// --------------------
	// Buttons
	button_debounce u_start_db (
		.clock_50 (clock_50),
		.rst      (rst),
		.button_n (start_n),
		.press    (start_press)
	);
	button_debounce u_left_db (
		.clock_50 (clock_50),
		.rst      (rst),
		.button_n (left_n),
		.press    (left_press)
	);
	button_debounce u_right_db (
		.clock_50 (clock_50),
		.rst      (rst),
		.button_n (right_n),
		.press    (right_press)
	);

	// --------------------
	// Game core
	game_fsm u_fsm (
		.clock_50    (clock_50),
		.rst         (rst),
		.start_press (start_press),
		.gif         (gif.ctrl)
	);
	step_timer u_timer (
		.clock_50 (clock_50),
		.rst      (rst),
		.gif      (gif.timer)
	);
	playfield u_field (
		.clock_50    (clock_50),
		.rst         (rst),
		.left_press  (left_press),
		.right_press (right_press),
		.gif         (gif.field),
		.frame       (frame)
	);

	// Matrix output
	max7219_driver u_drv (
		.clock_50    (clock_50),
		.rst         (rst),
		.frame       (frame),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

/* verilog/step_timer.sv */
// Step timer
// Paces the game with one step pulse per period, period halves per level
`timescale 1ns/100ps
`default_nettype none
`include "game_params.svh"

module step_timer (
	input  logic    clock_50,
	input  logic    rst,
	game_if.timer   gif
);
	import game_pkg::*;

	localparam int CNT_W = $clog2(`STEP_BASE_CYCLES);

	logic [CNT_W-1:0] count;
	// Terminal count for the current level
	logic [CNT_W-1:0] last;

	always_comb begin
		last = CNT_W'((`STEP_BASE_CYCLES >> gif.level) - 1);
	end

	always_ff @(posedge clock_50) begin
		if (rst || gif.screen != SCREEN_PLAY) begin
			// Held idle outside play
			count    <= '0;
			gif.step <= 1'b0;
		end else if (count == last) begin
			count    <= '0;
			gif.step <= 1'b1;
		end else begin
			count    <= count + 1'b1;
			gif.step <= 1'b0;
		end
	end

endmodule

`default_nettype wire
